/* design/dcache_geometry_pkg.sv */
package dcache_geometry_pkg;

    // 8 sets x 4 ways x 8-byte blocks over 16 address bits
    localparam int num_sets    = 8;
    localparam int num_ways    = 4;
    localparam int set_bits    = 3;
    localparam int way_bits    = 2;
    localparam int tag_bits    = 10;
    localparam int offset_bits = 3;

    typedef logic [set_bits-1:0] set_idx_t;
    typedef logic [way_bits-1:0] way_idx_t;

    // tree bits {right node, left node, root}
    typedef logic [2:0] plru_bits_t;

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        set_idx_t               set;
        logic [offset_bits-1:0] offset;
    } cache_addr_t;

    // one block seen at every load and store width
    typedef union packed {
        logic [63:0]            whole;
        logic [1:0][31:0]       words;
        logic [3:0][15:0]       halves;
        logic [7:0][7:0]        bytes;
    } block_data_t;

    typedef struct packed {
        logic                   valid;
        logic [tag_bits-1:0]    tag;
        block_data_t            data;
    } cache_line_t;

endpackage

/* design/dcache_bus_pkg.sv */
package dcache_bus_pkg;

    typedef enum logic [1:0] {
        mem_byte,
        mem_half,
        mem_word,
        mem_double
    } mem_size_t;

    typedef enum logic [1:0] {
        bus_none,
        bus_load,
        bus_store
    } bus_command_t;

    // zero means no transaction
    typedef logic [3:0] mem_tag_t;

    typedef struct packed {
        logic           valid;
        logic [31:0]    addr;
        mem_size_t      size;
        logic           load_signed;
        logic [5:0]     prf_idx;
        logic [4:0]     rob_idx;
    } load_req_t;

    typedef struct packed {
        logic           valid;
        logic [31:0]    addr;
        mem_size_t      size;
        logic [63:0]    data;
    } store_req_t;

    typedef struct packed {
        logic           valid;
        logic [31:0]    value;
        logic [5:0]     prf_idx;
        logic [4:0]     rob_idx;
    } cdb_result_t;

    typedef struct packed {
        bus_command_t   command;
        logic [31:0]    addr;
        mem_size_t      size;
        logic [63:0]    data;
    } mem_request_t;

    typedef struct packed {
        mem_tag_t       accept_tag;
        mem_tag_t       data_tag;
        logic [63:0]    data;
    } mem_response_t;

endpackage

/* design/plru_tree.sv */
`timescale 1ns/1ps

module plru_tree (
    input  logic                            clock,
    input  logic                            reset,
    input  dcache_geometry_pkg::set_idx_t   lookup_set,
    input  logic                            update,
    input  dcache_geometry_pkg::set_idx_t   update_set,
    input  dcache_geometry_pkg::way_idx_t   update_way,
    output dcache_geometry_pkg::way_idx_t   victim_way
);

    dcache_geometry_pkg::plru_bits_t trees [dcache_geometry_pkg::num_sets];
    dcache_geometry_pkg::plru_bits_t lookup_bits;

    // root picks the half, then that half's node picks the way
    assign lookup_bits = trees[lookup_set];

    always_comb begin
        if (lookup_bits[0]) begin
            victim_way = {1'b1, lookup_bits[2]};
        end else begin
            victim_way = {1'b0, lookup_bits[1]};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < dcache_geometry_pkg::num_sets; s++) begin
                trees[s] <= '0;
            end
        end else if (update) begin
            // point root and the used node away from the way just touched
            trees[update_set][0] <= ~update_way[1];
            if (update_way[1]) begin
                trees[update_set][2] <= ~update_way[0];
            end else begin
                trees[update_set][1] <= ~update_way[0];
            end
        end
    end

endmodule

/* design/dcache_array.sv */
`timescale 1ns/1ps

module dcache_array (
    input  logic                                clock,
    input  logic                                reset,
    input  dcache_bus_pkg::load_req_t           load_req,
    input  dcache_bus_pkg::store_req_t          store_req,
    output logic                                load_hit,
    output dcache_geometry_pkg::block_data_t    hit_block,
    input  logic                                fill,
    input  logic [31:0]                         fill_addr,
    input  dcache_geometry_pkg::block_data_t    fill_block
);

    localparam int num_sets = dcache_geometry_pkg::num_sets;
    localparam int num_ways = dcache_geometry_pkg::num_ways;

    dcache_geometry_pkg::cache_line_t   lines [num_sets][num_ways];
    dcache_geometry_pkg::cache_addr_t   load_a, store_a, fill_a;
    dcache_geometry_pkg::way_idx_t      load_way, store_way, fill_way, victim_way;
    dcache_geometry_pkg::way_idx_t      plru_way;
    dcache_geometry_pkg::set_idx_t      plru_set;
    dcache_geometry_pkg::block_data_t   merged;
    logic                               load_match, store_match, store_hit;
    logic                               do_fill, plru_update;

    assign load_a  = load_req.addr[15:0];
    assign store_a = store_req.addr[15:0];
    assign fill_a  = fill_addr[15:0];

    // load and store each search their own set
    always_comb begin
        load_match  = 1'b0;
        load_way    = '0;
        store_match = 1'b0;
        store_way   = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (lines[load_a.set][w].valid && lines[load_a.set][w].tag == load_a.tag) begin
                load_match = 1'b1;
                load_way   = dcache_geometry_pkg::way_idx_t'(w);
            end
            if (lines[store_a.set][w].valid && lines[store_a.set][w].tag == store_a.tag) begin
                store_match = 1'b1;
                store_way   = dcache_geometry_pkg::way_idx_t'(w);
            end
        end
    end

    assign load_hit  = load_req.valid && load_match;
    assign store_hit = store_req.valid && store_match;
    assign hit_block = lines[load_a.set][load_way].data;

    // a done head fills only when no hit owns the result bus
    assign do_fill = fill && !load_hit;

    always_comb begin
        merged = lines[store_a.set][store_way].data;
        case (store_req.size)
            dcache_bus_pkg::mem_byte: merged.bytes[store_a.offset] = store_req.data[7:0];
            dcache_bus_pkg::mem_half: merged.halves[store_a.offset[2:1]] = store_req.data[15:0];
            dcache_bus_pkg::mem_word: merged.words[store_a.offset[2]] = store_req.data[31:0];
            default:                  merged.whole = store_req.data;
        endcase
    end

    // lowest invalid way, else plru victim
    always_comb begin
        fill_way = victim_way;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!lines[fill_a.set][w].valid) begin
                fill_way = dcache_geometry_pkg::way_idx_t'(w);
            end
        end
        // two misses to one block refill the same way
        for (int w = 0; w < num_ways; w++) begin
            if (lines[fill_a.set][w].valid && lines[fill_a.set][w].tag == fill_a.tag) begin
                fill_way = dcache_geometry_pkg::way_idx_t'(w);
            end
        end
    end

    // load events first, then fill, then store hit
    always_comb begin
        plru_update = 1'b1;
        plru_set    = load_a.set;
        plru_way    = load_way;
        if (do_fill) begin
            plru_set = fill_a.set;
            plru_way = fill_way;
        end else if (!load_hit) begin
            plru_update = store_hit;
            plru_set    = store_a.set;
            plru_way    = store_way;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < num_sets; s++) begin
                for (int w = 0; w < num_ways; w++) begin
                    lines[s][w].valid <= 1'b0;
                end
            end
        end else begin
            if (store_hit) begin
                lines[store_a.set][store_way].data <= merged;
            end
            if (do_fill) begin
                lines[fill_a.set][fill_way].valid <= 1'b1;
                lines[fill_a.set][fill_way].tag   <= fill_a.tag;
                lines[fill_a.set][fill_way].data  <= fill_block;
            end
        end
    end

    plru_tree u_plru_tree (
        .clock      (clock),
        .reset      (reset),
        .lookup_set (fill_a.set),
        .update     (plru_update),
        .update_set (plru_set),
        .update_way (plru_way),
        .victim_way (victim_way)
    );

endmodule

/* design/load_miss_buffer.sv */
`timescale 1ns/1ps

module load_miss_buffer #(
    parameter int load_buffer_depth = 8
) (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                flush,
    input  dcache_bus_pkg::load_req_t           load_req,
    input  logic                                load_hit,
    input  dcache_bus_pkg::store_req_t          store_req,
    input  dcache_bus_pkg::mem_response_t       mem_response,
    input  logic                                head_retire,
    output dcache_bus_pkg::mem_request_t        mem_request,
    output logic                                head_done,
    output dcache_bus_pkg::load_req_t           head,
    output dcache_geometry_pkg::block_data_t    head_block,
    output logic                                full
);

    localparam int ptr_bits = $clog2(load_buffer_depth);

    typedef struct packed {
        logic                               valid;
        logic                               done;
        dcache_bus_pkg::mem_tag_t           mem_tag;
        dcache_bus_pkg::load_req_t          req;
        dcache_geometry_pkg::block_data_t   data;
    } entry_t;

    entry_t                 entries [load_buffer_depth];
    logic [ptr_bits-1:0]    head_ptr, tail_ptr, send_ptr;
    logic                   allocate, read_pending, read_accepted;

    assign full       = (head_ptr == tail_ptr) && entries[head_ptr].valid;
    assign head_done  = entries[head_ptr].valid && entries[head_ptr].done;
    assign head       = entries[head_ptr].req;
    assign head_block = entries[head_ptr].data;

    assign allocate = load_req.valid && !load_hit && !full;

    // tag stays zero until memory accepts the read
    assign read_pending  = entries[send_ptr].valid && entries[send_ptr].mem_tag == '0;
    assign read_accepted = !store_req.valid && read_pending && mem_response.accept_tag != '0;

    // stores win the memory port in their own cycle
    always_comb begin
        mem_request = '0;
        if (store_req.valid) begin
            mem_request.command = dcache_bus_pkg::bus_store;
            mem_request.addr    = store_req.addr;
            mem_request.size    = store_req.size;
            mem_request.data    = store_req.data;
        end else if (read_pending) begin
            mem_request.command = dcache_bus_pkg::bus_load;
            mem_request.addr    = {entries[send_ptr].req.addr[31:3], 3'b000};
            mem_request.size    = dcache_bus_pkg::mem_double;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            for (int i = 0; i < load_buffer_depth; i++) begin
                entries[i].valid   <= 1'b0;
                entries[i].done    <= 1'b0;
                entries[i].mem_tag <= '0;
            end
            head_ptr <= '0;
            tail_ptr <= '0;
            send_ptr <= '0;
        end else begin
            // returned block goes to whichever entry holds its tag
            for (int i = 0; i < load_buffer_depth; i++) begin
                if (entries[i].valid && !entries[i].done && entries[i].mem_tag != '0 &&
                        entries[i].mem_tag == mem_response.data_tag) begin
                    entries[i].done <= 1'b1;
                    entries[i].data <= mem_response.data;
                end
            end
            if (read_accepted) begin
                entries[send_ptr].mem_tag <= mem_response.accept_tag;
                send_ptr <= send_ptr + 1'b1;
            end
            if (allocate) begin
                entries[tail_ptr].valid   <= 1'b1;
                entries[tail_ptr].done    <= 1'b0;
                entries[tail_ptr].mem_tag <= '0;
                entries[tail_ptr].req     <= load_req;
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (head_retire) begin
                entries[head_ptr].valid <= 1'b0;
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

endmodule

/* design/load_result_format.sv */
`timescale 1ns/1ps

module load_result_format (
    input  dcache_bus_pkg::load_req_t           load_req,
    input  logic                                load_hit,
    input  dcache_geometry_pkg::block_data_t    hit_block,
    input  logic                                head_done,
    input  dcache_bus_pkg::load_req_t           head,
    input  dcache_geometry_pkg::block_data_t    head_block,
    output dcache_bus_pkg::cdb_result_t         cdb,
    output logic                                head_retire
);

    dcache_bus_pkg::load_req_t          sel;
    dcache_geometry_pkg::block_data_t   blk;
    logic [7:0]                         byte_val;
    logic [15:0]                        half_val;

    // a hit takes the bus, the done head waits
    assign sel         = load_hit ? load_req : head;
    assign blk         = load_hit ? hit_block : head_block;
    assign head_retire = head_done && !load_hit;

    assign byte_val = blk.bytes[sel.addr[2:0]];
    assign half_val = blk.halves[sel.addr[2:1]];

    always_comb begin
        cdb.valid   = load_hit || head_done;
        cdb.prf_idx = sel.prf_idx;
        cdb.rob_idx = sel.rob_idx;
        case (sel.size)
            dcache_bus_pkg::mem_byte: cdb.value = {{24{sel.load_signed & byte_val[7]}}, byte_val};
            dcache_bus_pkg::mem_half: cdb.value = {{16{sel.load_signed & half_val[15]}}, half_val};
            default:                  cdb.value = blk.words[sel.addr[2]];
        endcase
    end

endmodule

/* design/dcache.sv */
`timescale 1ns/1ps

module dcache #(
    parameter int load_buffer_depth = 8
) (
    input  logic                            clock,
    input  logic                            reset,
    input  dcache_bus_pkg::load_req_t       load_req,
    input  dcache_bus_pkg::store_req_t      store_req,
    input  logic                            flush,
    input  dcache_bus_pkg::mem_response_t   mem_response,
    output dcache_bus_pkg::cdb_result_t     cdb,
    output logic                            load_buffer_full,
    output dcache_bus_pkg::mem_request_t    mem_request
);

    logic                               load_hit, head_done, head_retire;
    dcache_geometry_pkg::block_data_t   hit_block, head_block;
    dcache_bus_pkg::load_req_t          head;

    dcache_array u_dcache_array (
        .clock      (clock),
        .reset      (reset),
        .load_req   (load_req),
        .store_req  (store_req),
        .load_hit   (load_hit),
        .hit_block  (hit_block),
        .fill       (head_done),
        .fill_addr  (head.addr),
        .fill_block (head_block)
    );

    load_miss_buffer #(
        .load_buffer_depth (load_buffer_depth)
    ) u_load_miss_buffer (
        .clock        (clock),
        .reset        (reset),
        .flush        (flush),
        .load_req     (load_req),
        .load_hit     (load_hit),
        .store_req    (store_req),
        .mem_response (mem_response),
        .head_retire  (head_retire),
        .mem_request  (mem_request),
        .head_done    (head_done),
        .head         (head),
        .head_block   (head_block),
        .full         (load_buffer_full)
    );

    load_result_format u_load_result_format (
        .load_req    (load_req),
        .load_hit    (load_hit),
        .hit_block   (hit_block),
        .head_done   (head_done),
        .head        (head),
        .head_block  (head_block),
        .cdb         (cdb),
        .head_retire (head_retire)
    );

endmodule

/* sim/dcache_assert.sv */
`timescale 1ns/1ps

module dcache_assert (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            flush,
    input  logic                            load_buffer_full,
    input  dcache_bus_pkg::load_req_t       load_req,
    input  dcache_bus_pkg::store_req_t      store_req,
    input  dcache_bus_pkg::mem_request_t    mem_request,
    input  dcache_bus_pkg::cdb_result_t     cdb
);

    // loads presented minus results delivered
    logic [7:0] in_flight;

    always_ff @(posedge clock) begin
        if (reset || flush) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + 8'(load_req.valid) - 8'(cdb.valid);
        end
    end

    // nothing can be delivered straight out of reset
    no_result_after_reset: assert property (@(posedge clock) $fell(reset) |-> !cdb.valid)
        else $error("result bus valid in the first cycle after reset");

    store_owns_port: assert property (@(posedge clock) disable iff (reset)
        (mem_request.command == dcache_bus_pkg::bus_store) == store_req.valid)
        else $error("store command does not follow the store request");

    // block reads are whole aligned blocks
    read_is_block: assert property (@(posedge clock) disable iff (reset)
        mem_request.command == dcache_bus_pkg::bus_load |->
            mem_request.size == dcache_bus_pkg::mem_double && mem_request.addr[2:0] == 3'b000)
        else $error("block read with wrong size or offset");

    empty_not_full: assert property (@(posedge clock) disable iff (reset)
        in_flight == '0 |-> !load_buffer_full)
        else $error("load buffer full while empty");

endmodule

bind dcache dcache_assert u_dcache_assert (.*);

/* sim/dcache_tb.sv */
`timescale 1ns/1ps

module dcache_tb;

    localparam int buffer_depth = 8;

    logic                           clock = 1'b0;
    logic                           reset = 1'b1;
    logic                           flush = 1'b0;
    dcache_bus_pkg::load_req_t      load_req = '0;
    dcache_bus_pkg::store_req_t     store_req = '0;
    dcache_bus_pkg::mem_response_t  mem_response = '0;
    dcache_bus_pkg::cdb_result_t    cdb;
    dcache_bus_pkg::mem_request_t   mem_request;
    logic                           load_buffer_full;

    integer                         seed = 56;
    int                             errors = 0;
    int                             checks = 0;
    int                             test_start = 0;
    // four sets by six tags indexed by tag * 4 + set
    logic [63:0]                    memory [24];
    logic [63:0]                    tag_data [16];
    logic [15:0]                    tag_busy = '0;
    dcache_bus_pkg::cdb_result_t    expect_q [$];
    int                             block_q [$];
    logic [31:0]                    send_q [$];
    logic [5:0]                     next_prf = '0;
    logic                           last_hit = 1'b0;

    dcache #(.load_buffer_depth(buffer_depth)) u_dcache (.*);

    always #5 clock = ~clock;

    function automatic int block_of(input logic [31:0] addr);
        return int'(addr[15:6]) * 4 + int'(addr[4:3]);
    endfunction

    function automatic logic [31:0] random_addr(input dcache_bus_pkg::mem_size_t size);
        logic [2:0] offset;
        // aligned to the access size
        offset = 3'($random(seed)) & ~3'((1 << size) - 1);
        return {16'h0, 10'($unsigned($random(seed)) % 6),
                3'($unsigned($random(seed)) % 4), offset};
    endfunction

    function automatic logic [31:0] load_value(input logic [63:0] blk,
                                               input dcache_bus_pkg::load_req_t req);
        logic [63:0] shifted;
        shifted = blk >> (8 * req.addr[2:0]);
        case (req.size)
            dcache_bus_pkg::mem_byte:
                return req.load_signed ? 32'(signed'(shifted[7:0])) : 32'(shifted[7:0]);
            dcache_bus_pkg::mem_half:
                return req.load_signed ? 32'(signed'(shifted[15:0])) : 32'(shifted[15:0]);
            default:
                return shifted[31:0];
        endcase
    endfunction

    function automatic logic [63:0] merge_store(input logic [63:0] blk,
                                                input dcache_bus_pkg::store_req_t st);
        for (int i = 0; i < (1 << st.size); i++) begin
            blk[(st.addr[2:0] + i) * 8 +: 8] = st.data[i * 8 +: 8];
        end
        return blk;
    endfunction

    function automatic logic block_pending(input int blk);
        foreach (block_q[i]) begin
            if (block_q[i] == blk) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic logic prf_in_use(input logic [5:0] prf);
        foreach (expect_q[i]) begin
            if (expect_q[i].prf_idx == prf) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_cdb(input dcache_bus_pkg::cdb_result_t got,
                             input dcache_bus_pkg::cdb_result_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: result bus %h, expected %h", $time, got, want);
        end
    endtask

    task automatic check_request(input dcache_bus_pkg::mem_request_t got,
                                 input dcache_bus_pkg::mem_request_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: memory request %h, expected %h", $time, got, want);
        end
    endtask

    task automatic check_full(input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERROR %0t: load buffer full %b, expected %b", $time, got, want);
        end
    endtask

    // prf index kept unique among outstanding misses
    task automatic make_load(input dcache_bus_pkg::mem_size_t size, input logic [31:0] addr,
                             output dcache_bus_pkg::load_req_t ld);
        while (prf_in_use(next_prf)) begin
            next_prf++;
        end
        ld = '{1'b1, addr, size, 1'($random(seed)), next_prf, next_prf[4:0]};
        next_prf++;
    endtask

    // check the memory request, then maybe return a block and accept a read
    task automatic serve_memory(input dcache_bus_pkg::store_req_t st);
        dcache_bus_pkg::mem_request_t want;
        int start;
        int freed;
        int taken;
        want  = '0;
        freed = 0;
        taken = 0;
        if (st.valid) begin
            want = '{dcache_bus_pkg::bus_store, st.addr, st.size, st.data};
        end else if (send_q.size() > 0) begin
            want = '{dcache_bus_pkg::bus_load, send_q[0], dcache_bus_pkg::mem_double, 64'h0};
        end
        check_request(mem_request, want);
        mem_response = '0;
        start = int'($unsigned($random(seed)) % 15);
        if ($random(seed) % 2 == 0) begin
            for (int k = 0; k < 15 && freed == 0; k++) begin
                if (tag_busy[(start + k) % 15 + 1]) begin
                    freed = (start + k) % 15 + 1;
                end
            end
        end
        // one read in four is refused
        if (want.command == dcache_bus_pkg::bus_load && $random(seed) % 4 != 0) begin
            for (int k = 0; k < 15 && taken == 0; k++) begin
                if (!tag_busy[(start + k) % 15 + 1]) begin
                    taken = (start + k) % 15 + 1;
                end
            end
        end
        if (taken != 0) begin
            tag_busy[taken] = 1'b1;
            tag_data[taken] = memory[block_of(send_q[0])];
            mem_response.accept_tag = 4'(taken);
            void'(send_q.pop_front());
        end
        if (freed != 0) begin
            tag_busy[freed] = 1'b0;
            mem_response.data_tag = 4'(freed);
            mem_response.data     = tag_data[freed];
        end
    endtask

    task automatic collect_results(input dcache_bus_pkg::load_req_t ld,
                                   input dcache_bus_pkg::cdb_result_t want, input logic fl);
        last_hit = ld.valid && cdb.valid && cdb.prf_idx == ld.prf_idx;
        if (last_hit) begin
            check_cdb(cdb, want);
        end else if (cdb.valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("result for prf %0d appeared with no load outstanding", cdb.prf_idx);
            end else begin
                check_cdb(cdb, expect_q.pop_front());
                void'(block_q.pop_front());
            end
        end
        if (ld.valid && !last_hit) begin
            expect_q.push_back(want);
            block_q.push_back(block_of(ld.addr));
            send_q.push_back({ld.addr[31:3], 3'b000});
        end
        if (fl) begin
            expect_q.delete();
            block_q.delete();
            send_q.delete();
        end
    endtask

    // entered and left 1 ns after a rising edge
    task automatic run_cycle(input dcache_bus_pkg::load_req_t ld,
                             input dcache_bus_pkg::store_req_t st, input logic fl);
        dcache_bus_pkg::cdb_result_t want;
        check_full(load_buffer_full, expect_q.size() == buffer_depth);
        want = '{1'b1, load_value(memory[block_of(ld.addr)], ld), ld.prf_idx, ld.rob_idx};
        load_req  = ld;
        store_req = st;
        flush     = fl;
        if (st.valid) begin
            memory[block_of(st.addr)] = merge_store(memory[block_of(st.addr)], st);
        end
        #1;
        serve_memory(st);
        @(negedge clock);
        collect_results(ld, want, fl);
        @(posedge clock);
        #1;
    endtask

    task automatic random_traffic(input int cycles, input int load_pct);
        dcache_bus_pkg::load_req_t  ld;
        dcache_bus_pkg::store_req_t st;
        dcache_bus_pkg::mem_size_t  size;
        repeat (cycles) begin
            ld = '0;
            st = '0;
            if (!load_buffer_full && $unsigned($random(seed)) % 100 < load_pct) begin
                size = dcache_bus_pkg::mem_size_t'($unsigned($random(seed)) % 3);
                make_load(size, random_addr(size), ld);
            end
            if ($random(seed) % 4 == 0) begin
                size = dcache_bus_pkg::mem_size_t'($unsigned($random(seed)) % 4);
                st = '{1'b1, random_addr(size), size, {$random(seed), $random(seed)}};
                // keep away from blocks with a miss in flight
                if (block_pending(block_of(st.addr)) ||
                        (ld.valid && block_of(st.addr) == block_of(ld.addr))) begin
                    st = '0;
                end
            end
            run_cycle(ld, st, 1'b0);
        end
    endtask

    task automatic drain(input string what);
        int waited;
        waited = 0;
        while (expect_q.size() > 0 && waited < 500) begin
            run_cycle('0, '0, 1'b0);
            waited++;
        end
        if (expect_q.size() > 0) begin
            errors++;
            $display("timed out after %0d cycles waiting for %s", waited, what);
        end
    endtask

    task automatic hit_after_fill(input int rounds);
        dcache_bus_pkg::load_req_t  ld;
        logic [31:0]                addr;
        repeat (rounds) begin
            addr = random_addr(dcache_bus_pkg::mem_word);
            make_load(dcache_bus_pkg::mem_word, addr, ld);
            run_cycle(ld, '0, 1'b0);
            drain("the first load of a block");
            make_load(dcache_bus_pkg::mem_byte, {addr[31:3], 3'($random(seed))}, ld);
            run_cycle(ld, '0, 1'b0);
            if (!last_hit) begin
                errors++;
                $display("load to a filled block did not return in its own cycle");
            end
        end
    endtask

    task automatic flush_rounds(input int rounds);
        repeat (rounds) begin
            random_traffic(30, 80);
            run_cycle('0, '0, 1'b1);
            check_full(load_buffer_full, 1'b0);
            random_traffic(60, 50);
        end
    endtask

    task automatic report_test(input string name);
        drain("outstanding misses");
        $display("test %s: %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    initial begin
        for (int i = 0; i < 24; i++) begin
            memory[i] = {$random(seed), $random(seed)};
        end
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;
        random_traffic(2000, 50);
        report_test("random loads and stores");
        hit_after_fill(40);
        report_test("hit after fill");
        random_traffic(600, 95);
        report_test("misses under back-pressure");
        flush_rounds(8);
        report_test("flush");
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* dcache.f */
design/dcache_geometry_pkg.sv
design/dcache_bus_pkg.sv
design/plru_tree.sv
design/dcache_array.sv
design/load_miss_buffer.sv
design/load_result_format.sv
design/dcache.sv
sim/dcache_assert.sv
sim/dcache_tb.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - design/dcache_geometry_pkg.sv
  - design/dcache_bus_pkg.sv
  - design/plru_tree.sv
  - design/dcache_array.sv
  - design/load_miss_buffer.sv
  - design/load_result_format.sv
  - design/dcache.sv
  - target: simulation
    files:
      - sim/dcache_assert.sv
      - sim/dcache_tb.sv
